// ==== include/wisc_defs.svh ====
`ifndef WISC_DEFS_SVH
`define WISC_DEFS_SVH

// Register and datapath width
`define WISC_DATA_W 16

// Architectural registers r0 to r7
`define WISC_REG_CNT 8

// Instruction queue entries
`define WISC_INSTR_DEPTH 4

// Event queue entries
`define WISC_EVENT_DEPTH 4

`endif

// ==== hw/wisc_pkg.sv ====
`include "wisc_defs.svh"

package wisc_pkg;

    // Opcode field in instruction bits 15 to 11
    typedef enum logic [4:0] {
        opHalt   = 5'b00000,
        opNop    = 5'b00001,
        opStartF = 5'b00010,
        opStartI = 5'b00011,
        opJ      = 5'b00100,
        opJr     = 5'b00101,
        opJal    = 5'b00110,
        opJalr   = 5'b00111,
        opAddi   = 5'b01000,
        opSubi   = 5'b01001,
        opXori   = 5'b01010,
        opAndni  = 5'b01011,
        opBeqz   = 5'b01100,
        opBnez   = 5'b01101,
        opBltz   = 5'b01110,
        opBgez   = 5'b01111,
        opSt     = 5'b10000,
        opLd     = 5'b10001,
        opSlbi   = 5'b10010,
        opStu    = 5'b10011,
        opLbi    = 5'b10100,
        opAdd    = 5'b11000,
        opSub    = 5'b11001,
        opXor    = 5'b11010,
        opAndn   = 5'b11011,
        opSeq    = 5'b11100,
        opSlt    = 5'b11101,
        opSle    = 5'b11110,
        opLoadF  = 5'b11111
    } opcode_e;

    // ALU operation select
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluXor  = 4'd2,
        aluAndn = 4'd3,
        aluBeqz = 4'd4,
        aluBnez = 4'd5,
        aluBltz = 4'd6,
        aluBgez = 4'd7,
        aluSeq  = 4'd8,
        aluSlt  = 4'd9,
        aluSle  = 4'd10,
        aluLbi  = 4'd11,
        aluSlbi = 4'd12
    } aluOp_e;

    // What an output event reports
    typedef enum logic [1:0] {
        evRegWrite = 2'd0,
        evAccelCmd = 2'd1,
        evHalt     = 2'd2
    } eventKind_e;

    // Event queue payload of 21 bits
    typedef struct packed {
        eventKind_e                 kind;
        logic [2:0]                 regIdx;
        logic [`WISC_DATA_W-1:0]    data;
    } execEvent_t;

endpackage

// ==== hw/streamFifo.sv ====
`timescale 1ns/1ns

module streamFifo #(
    parameter type T = logic [15:0],
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    output logic inReady,
    input  T     inData,
    output logic outValid,
    input  logic outReady,
    output T     outData
);

    localparam int ptrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cntWidth = $clog2(DEPTH + 1);

    // Payload storage
    T mem [DEPTH];

    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] count;
    logic                full;
    logic                push;
    logic                pop;

    // Wrap at DEPTH so non power of two depths work too
    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == cntWidth'(DEPTH));
    assign outValid = (count != '0);
    // A pop in the same cycle frees the slot being written
    assign inReady  = !full || outReady;
    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;
    assign outData  = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Occupancy only moves on push xor pop
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit (
    input  logic [4:0]       opcode,
    output logic             isJAL,
    output logic             regDst,
    output logic             rsWrite,
    output logic             regWrite,
    output logic             aluSrc,
    output logic             isSignExtend,
    output logic             isIType1,
    output logic             isBranch,
    output logic             nop,
    output logic             halt,
    output logic             memWrite,
    output logic             memRead,
    output logic             memToReg,
    output logic             isJR,
    output logic             isSLBI,
    output wisc_pkg::aluOp_e aluOp,
    output logic             isJump,
    output logic             startI,
    output logic             startF,
    output logic             loadF
);

    always_comb begin
        // Everything inactive unless the opcode says otherwise
        isJAL        = 1'b0;
        regDst       = 1'b0;
        rsWrite      = 1'b0;
        regWrite     = 1'b0;
        aluSrc       = 1'b0;
        isSignExtend = 1'b0;
        isIType1     = 1'b0;
        isBranch     = 1'b0;
        nop          = 1'b0;
        halt         = 1'b0;
        memWrite     = 1'b0;
        memRead      = 1'b0;
        memToReg     = 1'b0;
        isJR         = 1'b0;
        isSLBI       = 1'b0;
        aluOp        = wisc_pkg::aluAdd;
        isJump       = 1'b0;
        startI       = 1'b0;
        startF       = 1'b0;
        loadF        = 1'b0;

        case (wisc_pkg::opcode_e'(opcode))
            // Special instructions
            wisc_pkg::opHalt:   halt = 1'b1;
            wisc_pkg::opNop:    nop = 1'b1;
            wisc_pkg::opStartF: startF = 1'b1;
            wisc_pkg::opStartI: startI = 1'b1;
            wisc_pkg::opLoadF:  loadF = 1'b1;

            // I format 1 with the immediate in bits 4 to 0
            wisc_pkg::opAddi: begin
                aluOp        = wisc_pkg::aluAdd;
                regWrite     = 1'b1;
                isIType1     = 1'b1;
                isSignExtend = 1'b1;
            end
            wisc_pkg::opSubi: begin
                aluOp        = wisc_pkg::aluSub;
                regWrite     = 1'b1;
                isIType1     = 1'b1;
                isSignExtend = 1'b1;
            end
            // Logical immediates zero extend
            wisc_pkg::opXori: begin
                aluOp    = wisc_pkg::aluXor;
                regWrite = 1'b1;
                isIType1 = 1'b1;
            end
            wisc_pkg::opAndni: begin
                aluOp    = wisc_pkg::aluAndn;
                regWrite = 1'b1;
                isIType1 = 1'b1;
            end
            // Memory address is rs plus offset
            wisc_pkg::opSt: begin
                aluOp        = wisc_pkg::aluAdd;
                memWrite     = 1'b1;
                isIType1     = 1'b1;
                isSignExtend = 1'b1;
            end
            wisc_pkg::opLd: begin
                aluOp        = wisc_pkg::aluAdd;
                memRead      = 1'b1;
                memToReg     = 1'b1;
                regWrite     = 1'b1;
                isIType1     = 1'b1;
                isSignExtend = 1'b1;
            end
            // Store with rs update
            wisc_pkg::opStu: begin
                aluOp        = wisc_pkg::aluAdd;
                memWrite     = 1'b1;
                rsWrite      = 1'b1;
                regWrite     = 1'b1;
                isIType1     = 1'b1;
                isSignExtend = 1'b1;
            end

            // R format with rd in bits 4 to 2
            wisc_pkg::opAdd: begin
                regDst   = 1'b1;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = wisc_pkg::aluAdd;
            end
            wisc_pkg::opSub: begin
                regDst   = 1'b1;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = wisc_pkg::aluSub;
            end
            wisc_pkg::opXor: begin
                regDst   = 1'b1;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = wisc_pkg::aluXor;
            end
            wisc_pkg::opAndn: begin
                regDst   = 1'b1;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = wisc_pkg::aluAndn;
            end
            wisc_pkg::opSeq: begin
                regDst   = 1'b1;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = wisc_pkg::aluSeq;
            end
            wisc_pkg::opSlt: begin
                regDst   = 1'b1;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = wisc_pkg::aluSlt;
            end
            wisc_pkg::opSle: begin
                regDst   = 1'b1;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                aluOp    = wisc_pkg::aluSle;
            end

            // I format 2 branches on rs
            wisc_pkg::opBeqz: begin
                isBranch = 1'b1;
                aluOp    = wisc_pkg::aluBeqz;
            end
            wisc_pkg::opBnez: begin
                isBranch = 1'b1;
                aluOp    = wisc_pkg::aluBnez;
            end
            wisc_pkg::opBltz: begin
                isBranch = 1'b1;
                aluOp    = wisc_pkg::aluBltz;
            end
            wisc_pkg::opBgez: begin
                isBranch = 1'b1;
                aluOp    = wisc_pkg::aluBgez;
            end
            // Byte immediates write back into rs
            wisc_pkg::opLbi: begin
                aluOp    = wisc_pkg::aluLbi;
                rsWrite  = 1'b1;
                regWrite = 1'b1;
            end
            wisc_pkg::opSlbi: begin
                aluOp    = wisc_pkg::aluSlbi;
                rsWrite  = 1'b1;
                isSLBI   = 1'b1;
                regWrite = 1'b1;
            end
            wisc_pkg::opJr: isJR = 1'b1;
            wisc_pkg::opJalr: begin
                isJAL    = 1'b1;
                isJR     = 1'b1;
                regWrite = 1'b1;
            end

            // J format
            wisc_pkg::opJ: isJump = 1'b1;
            wisc_pkg::opJal: begin
                isJAL    = 1'b1;
                isJump   = 1'b1;
                regWrite = 1'b1;
            end

            // Undefined codes decode as inactive
            default: begin
            end
        endcase
    end

endmodule

// ==== hw/wiscAlu.sv ====
`timescale 1ns/1ns
`include "wisc_defs.svh"

module wiscAlu (
    input  wisc_pkg::aluOp_e        aluOp,
    input  logic [`WISC_DATA_W-1:0] opA,
    input  logic [`WISC_DATA_W-1:0] opB,
    output logic [`WISC_DATA_W-1:0] result
);

    // Signed views for the set-on-compare ops
    logic signed [`WISC_DATA_W-1:0] sA;
    logic signed [`WISC_DATA_W-1:0] sB;

    assign sA = opA;
    assign sB = opB;

    always_comb begin
        case (aluOp)
            wisc_pkg::aluAdd:  result = opA + opB;
            wisc_pkg::aluSub:  result = opA - opB;
            wisc_pkg::aluXor:  result = opA ^ opB;
            wisc_pkg::aluAndn: result = opA & ~opB;
            // Flags land in bit 0
            wisc_pkg::aluSeq:  result = {{(`WISC_DATA_W-1){1'b0}}, sA == sB};
            wisc_pkg::aluSlt:  result = {{(`WISC_DATA_W-1){1'b0}}, sA < sB};
            wisc_pkg::aluSle:  result = {{(`WISC_DATA_W-1){1'b0}}, sA <= sB};
            // Immediate already extended by the operand mux
            wisc_pkg::aluLbi:  result = opB;
            wisc_pkg::aluSlbi: begin
                result = (opA << 8) | {{(`WISC_DATA_W-8){1'b0}}, opB[7:0]};
            end
            // Branch codes have nothing to compute here
            default:           result = '0;
        endcase
    end

endmodule

// ==== hw/execStage.sv ====
`timescale 1ns/1ns
`include "wisc_defs.svh"

module execStage (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     instrValid,
    input  logic [15:0]              instrWord,
    output logic                     instrReady,
    output logic                     evValid,
    input  logic                     evReady,
    output wisc_pkg::eventKind_e     evKind,
    output logic [2:0]               evReg,
    output logic [`WISC_DATA_W-1:0]  evData,
    output logic                     halted
);

    logic [`WISC_DATA_W-1:0] regFile [`WISC_REG_CNT];

    // Decoded controls
    logic             isJAL, regDst, rsWrite, regWrite, aluSrc, isSignExtend;
    logic             isIType1, isHalt, memWrite, memRead, isSLBI;
    logic             startI, startF, loadF;
    wisc_pkg::aluOp_e aluOp;

    // Instruction fields
    logic [2:0]              rs, rt, rd, dstReg;
    logic [4:0]              imm5;
    logic [7:0]              imm8;
    logic [`WISC_DATA_W-1:0] opA, opB, aluResult;
    logic                    writeEn, isAccel, hasEvent, accept;

    assign rs   = instrWord[10:8];
    assign rt   = instrWord[7:5];
    assign rd   = instrWord[4:2];
    assign imm5 = instrWord[4:0];
    assign imm8 = instrWord[7:0];

    controlUnit ctrlUnit (
        .opcode(instrWord[15:11]), .isJAL(isJAL), .regDst(regDst), .rsWrite(rsWrite),
        .regWrite(regWrite), .aluSrc(aluSrc), .isSignExtend(isSignExtend),
        .isIType1(isIType1), .isBranch(), .nop(), .halt(isHalt), .memWrite(memWrite),
        .memRead(memRead), .memToReg(), .isJR(), .isSLBI(isSLBI), .aluOp(aluOp),
        .isJump(), .startI(startI), .startF(startF), .loadF(loadF)
    );

    // Second operand select
    assign opA = regFile[rs];
    always_comb begin
        if (aluSrc) begin
            opB = regFile[rt];
        end else if (isIType1) begin
            opB = {{(`WISC_DATA_W-5){isSignExtend & imm5[4]}}, imm5};
        end else if (isSLBI) begin
            opB = {{(`WISC_DATA_W-8){1'b0}}, imm8};
        end else begin
            // LBI
            opB = {{(`WISC_DATA_W-8){imm8[7]}}, imm8};
        end
    end

    wiscAlu alu (.aluOp(aluOp), .opA(opA), .opB(opB), .result(aluResult));

    always_comb begin
        if (regDst) begin
            dstReg = rd;
        end else if (rsWrite) begin
            dstReg = rs;
        end else begin
            dstReg = rt;
        end
    end

    // Loads, stores and links have no memory or PC here
    assign writeEn    = regWrite & ~memRead & ~memWrite & ~isJAL;
    assign isAccel    = startI | startF | loadF;
    assign hasEvent   = writeEn | isAccel | isHalt;
    // Any instruction may need an event slot
    assign instrReady = ~halted & evReady;
    assign accept     = instrValid & instrReady;
    assign evValid    = instrValid & ~halted & hasEvent;

    always_comb begin
        evKind = wisc_pkg::evRegWrite;
        evReg  = dstReg;
        evData = aluResult;
        if (isHalt) begin
            evKind = wisc_pkg::evHalt;
            evReg  = '0;
            evData = '0;
        end else if (isAccel) begin
            // Command index 0 STARTI, 1 STARTF, 2 LOADF
            evKind = wisc_pkg::evAccelCmd;
            evReg  = startI ? 3'd0 : (startF ? 3'd1 : 3'd2);
            evData = opA;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            halted <= 1'b0;
            for (int i = 0; i < `WISC_REG_CNT; i++) begin
                regFile[i] <= '0;
            end
        end else if (accept) begin
            if (writeEn) begin
                regFile[dstReg] <= aluResult;
            end
            // Sticky until reset
            if (isHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/wiscExecTop.sv ====
`timescale 1ns/1ns
`include "wisc_defs.svh"

module wiscExecTop (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    inValid,
    output logic                    inReady,
    input  logic [15:0]             inInstr,
    output logic                    outValid,
    input  logic                    outReady,
    output logic [1:0]              outKind,
    output logic [2:0]              outReg,
    output logic [`WISC_DATA_W-1:0] outData,
    output logic                    halted
);

    // Queue to execute
    logic        instrValid;
    logic        instrReady;
    logic [15:0] instrWord;

    // Execute to event queue
    logic                    evValid;
    logic                    evReady;
    wisc_pkg::eventKind_e    evKind;
    logic [2:0]              evReg;
    logic [`WISC_DATA_W-1:0] evData;
    wisc_pkg::execEvent_t    evPush;
    wisc_pkg::execEvent_t    evPop;

    streamFifo #(.T(logic [15:0]), .DEPTH(`WISC_INSTR_DEPTH)) instrQueue (
        .clk(clk), .rstN(rstN),
        .inValid(inValid), .inReady(inReady), .inData(inInstr),
        .outValid(instrValid), .outReady(instrReady), .outData(instrWord)
    );

    execStage execUnit (
        .clk(clk), .rstN(rstN),
        .instrValid(instrValid), .instrWord(instrWord), .instrReady(instrReady),
        .evValid(evValid), .evReady(evReady),
        .evKind(evKind), .evReg(evReg), .evData(evData), .halted(halted)
    );

    // Pack and unpack event fields
    assign evPush = '{kind: evKind, regIdx: evReg, data: evData};

    streamFifo #(.T(wisc_pkg::execEvent_t), .DEPTH(`WISC_EVENT_DEPTH)) eventQueue (
        .clk(clk), .rstN(rstN),
        .inValid(evValid), .inReady(evReady), .inData(evPush),
        .outValid(outValid), .outReady(outReady), .outData(evPop)
    );

    assign outKind = evPop.kind;
    assign outReg  = evPop.regIdx;
    assign outData = evPop.data;

endmodule

// ==== verification/wiscExec_chk.sv ====
`timescale 1ns/1ns

module wiscExec_chk (
    input logic        clk,
    input logic        rstN,
    input logic        inValid,
    input logic        inReady,
    input logic [15:0] inInstr,
    input logic        outValid,
    input logic        outReady,
    input logic [1:0]  outKind,
    input logic [2:0]  outReg,
    input logic [15:0] outData,
    input logic        halted
);

    // Number of failed assertions so far
    int failCount = 0;

    // Sender must hold the word while stalled
    inInstrStable: assert property (@(posedge clk) disable iff (!rstN)
        inValid && !inReady |=> $stable(inInstr))
        else begin
            $error("inInstr changed while inValid was stalled");
            failCount++;
        end

    // Event queue holds its head until taken
    outPayloadStable: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable({outKind, outReg, outData}))
        else begin
            $error("output event changed or vanished while outReady was low");
            failCount++;
        end

    outValidAfterReset: assert property (@(posedge clk)
        !rstN |=> !outValid)
        else begin
            $error("outValid high in the cycle after reset");
            failCount++;
        end

    // Halt is sticky until reset
    haltSticky: assert property (@(posedge clk)
        rstN && halted |=> halted)
        else begin
            $error("halted fell without a reset");
            failCount++;
        end

endmodule

bind wiscExecTop wiscExec_chk handshakeChk (
    .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady), .inInstr(inInstr),
    .outValid(outValid), .outReady(outReady), .outKind(outKind), .outReg(outReg),
    .outData(outData), .halted(halted)
);

// ==== verification/wiscExecTb.sv ====
`timescale 1ns/1ns

module wiscExecTb;

    localparam int clkPeriod = 40;

    logic        clk = 1'b0;
    logic        rstN;
    logic        inValid;
    logic        inReady;
    logic [15:0] inInstr;
    logic        outValid;
    logic        outReady;
    logic [1:0]  outKind;
    logic [2:0]  outReg;
    logic [15:0] outData;
    logic        halted;

    // Per test entries from the golden file
    string       testName [$];
    int          testMode [$];
    int          instrFirst [$];
    int          instrCount [$];
    // Per instruction entries
    logic [15:0] goldWord [$];
    logic        goldHasEv [$];
    logic [1:0]  goldKind [$];
    logic [2:0]  goldReg [$];
    logic [15:0] goldData [$];

    // Events still due in the running test
    logic [1:0]  expKind [$];
    logic [2:0]  expReg [$];
    logic [15:0] expData [$];

    int          errorCount = 0;
    int          testErrors = 0;
    int          testsFailed = 0;
    logic        holdLow;

    wiscExecTop DUT (
        .clk(clk), .rstN(rstN),
        .inValid(inValid), .inReady(inReady), .inInstr(inInstr),
        .outValid(outValid), .outReady(outReady),
        .outKind(outKind), .outReg(outReg), .outData(outData),
        .halted(halted)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: actual %h, expected %h", name, actual, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("%s", msg);
        errorCount++;
        testErrors++;
    endtask

    task automatic loadGolden();
        int          fd;
        int          code;
        string       tag;
        string       rest;
        string       name;
        int          mode;
        logic [15:0] word;
        logic [1:0]  kind;
        logic [2:0]  regIdx;
        logic [15:0] data;
        fd = $fopen("verification/wisc_golden.txt", "r");
        if (fd == 0) begin
            reportProblem("Cannot open the golden file verification/wisc_golden.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code == 1) begin
                if (tag == "#") begin
                    // Rest of a comment line
                    code = $fgets(rest, fd);
                end else if (tag == "T") begin
                    code = $fscanf(fd, "%s %d", name, mode);
                    testName.push_back(name);
                    testMode.push_back(mode);
                    instrFirst.push_back(goldWord.size());
                    instrCount.push_back(0);
                end else if (tag == "I" || tag == "E") begin
                    code = $fscanf(fd, "%h", word);
                    kind = '0;
                    regIdx = '0;
                    data = '0;
                    if (tag == "E") begin
                        code = $fscanf(fd, "%h %h %h", kind, regIdx, data);
                    end
                    goldWord.push_back(word);
                    goldHasEv.push_back(tag == "E");
                    goldKind.push_back(kind);
                    goldReg.push_back(regIdx);
                    goldData.push_back(data);
                    instrCount[instrCount.size() - 1]++;
                end else begin
                    reportProblem({"Golden file holds an unknown line tag ", tag});
                end
            end
        end
        $fclose(fd);
    endtask

    // Called 2 ns after a rising edge and returns at the same phase
    task automatic sendWord(input logic [15:0] word);
        logic accepted;
        inValid = 1'b1;
        inInstr = word;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = inReady;
            @(posedge clk);
            #2;
        end
        inValid = 1'b0;
    endtask

    task automatic driveWords(input int first, input int count);
        for (int i = first; i < first + count; i++) begin
            sendWord(goldWord[i]);
        end
    endtask

    // Stall the output long enough to back up both queues
    task automatic holdOutput();
        logic sawStall;
        sawStall = 1'b0;
        holdLow = 1'b1;
        outReady = 1'b0;
        repeat (40) begin
            @(negedge clk);
            if (!inReady) begin
                sawStall = 1'b1;
            end
        end
        holdLow = 1'b0;
        if (!sawStall) begin
            reportProblem("inReady never fell while outReady was held low");
        end
    endtask

    task automatic runTest(input int t);
        int first;
        int count;
        first = instrFirst[t];
        count = instrCount[t];
        testErrors = 0;
        for (int i = first; i < first + count; i++) begin
            if (goldHasEv[i]) begin
                expKind.push_back(goldKind[i]);
                expReg.push_back(goldReg[i]);
                expData.push_back(goldData[i]);
            end
        end
        fork
            driveWords(first, count);
            if (testMode[t] == 1) holdOutput();
        join
        while (expKind.size() != 0) begin
            @(posedge clk);
        end
        // Room for any stray event from the last words
        repeat (10) @(posedge clk);
        if (testMode[t] == 2) begin
            @(negedge clk);
            checkValue("halted", halted, 1'b1);
            checkValue("inReady", inReady, 1'b0);
        end
        @(posedge clk);
        #2;
        if (testErrors != 0) begin
            testsFailed++;
        end
        $display("Test %s: %s, %0d errors", testName[t],
                 (testErrors == 0) ? "passed" : "failed", testErrors);
    endtask

    // Random back-pressure that stays off during reset and hold windows
    always @(posedge clk) begin
        #2;
        if (holdLow || !rstN) begin
            outReady = 1'b0;
        end else begin
            outReady = ($urandom % 4) != 0;
        end
    end

    // Sample mid cycle since the transfer happens on the next rising edge
    always @(negedge clk) begin
        if (rstN === 1'b1 && outValid === 1'b1 && outReady === 1'b1) begin
            if (expKind.size() == 0) begin
                reportProblem($sformatf("Event kind %h reg %h data %h arrived unexpectedly",
                                        outKind, outReg, outData));
            end else begin
                checkValue("outKind", outKind, expKind.pop_front());
                checkValue("outReg", outReg, expReg.pop_front());
                checkValue("outData", outData, expData.pop_front());
            end
        end
    end

    initial begin
        int limitCycles;
        void'($urandom(41705));
        rstN = 1'b0;
        inValid = 1'b0;
        inInstr = '0;
        outReady = 1'b0;
        holdLow = 1'b0;
        loadGolden();
        limitCycles = goldWord.size() * 20 + 200;
        fork
            begin
                #(limitCycles * clkPeriod);
                $display("Run timed out after %0d cycles before all tests finished",
                         limitCycles);
                $display("Done: errors found");
                $finish;
            end
        join_none
        repeat (8) @(posedge clk);
        #2;
        rstN = 1'b1;
        for (int t = 0; t < testName.size(); t++) begin
            runTest(t);
        end
        if (DUT.handshakeChk.failCount != 0) begin
            $display("%0d handshake assertions failed during the run",
                     DUT.handshakeChk.failCount);
            errorCount += DUT.handshakeChk.failCount;
        end
        $display("%0d tests run, %0d failed, %0d errors", testName.size(), testsFailed,
                 errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== Bender.yml ====
package:
  name: wisc_exec

sources:
  - include_dirs:
      - include
    files:
      - hw/wisc_pkg.sv
      - hw/streamFifo.sv
      - hw/controlUnit.sv
      - hw/wiscAlu.sv
      - hw/execStage.sv
      - hw/wiscExecTop.sv
  - target: test
    files:
      - verification/wiscExec_chk.sv
      - verification/wiscExecTb.sv

// ==== wiscExecTop.f ====
+incdir+include
hw/wisc_pkg.sv
hw/streamFifo.sv
hw/controlUnit.sv
hw/wiscAlu.sv
hw/execStage.sv
hw/wiscExecTop.sv
verification/wiscExec_chk.sv
verification/wiscExecTb.sv

// ==== verification/wisc_golden.txt ====
# T name mode: mode 0 random outReady, 1 outReady held low 40 cycles, 2 halt checks
# I word: instruction, no event; E word kind reg data: instruction and its event, hex
T rtype 0
E A105 0 1 0005
E A2FD 0 2 FFFD
E C14C 0 3 0002
E C950 0 4 0008
E D154 0 5 FFF8
E D958 0 6 0000
E E15C 0 7 0000
E E13C 0 7 0001
E EA2C 0 3 0001
E E94C 0 3 0000
E F250 0 4 0001
E F150 0 4 0000
T itype 0
E 417E 0 3 0003
E 4B9F 0 4 0004
E 54BF 0 5 001B
E 5DD1 0 6 000A
E 46EF 0 7 0019
E 4A30 0 1 000D
T bytes 0
E A380 0 3 FF80
E A47F 0 4 007F
E 94C3 0 4 7FC3
E 9301 0 3 8001
T accel 0
E 1C00 1 0 7FC3
E 1300 1 1 8001
E FE00 1 2 000A
# Silent words, then read-back of r5, r1 and r7
I 0800
I 89A1
I 81A1
I 99A1
I 6004
I 6904
I 7204
I 7B04
I 2010
I 2D00
I 3010
I 3D00
I A800
I B000
I B800
E C514 0 5 001B
E C104 0 1 000D
E C71C 0 7 0019
T backpress 1
E 4121 0 1 000E
E 4121 0 1 000F
E 4121 0 1 0010
E 4121 0 1 0011
E 4121 0 1 0012
E 4121 0 1 0013
E 4121 0 1 0014
E 4121 0 1 0015
E 4121 0 1 0016
E 4121 0 1 0017
E 4121 0 1 0018
E 4121 0 1 0019
T halt 2
E A211 0 2 0011
E 0000 2 0 0000
I A2FF
I 1C00
I 4121
I C14C
